// File: trig_pkg.sv
package trig_pkg;

    ////////////////////
    // Widths

    // One ADC sample
    localparam int SAMPLE_W = 16;
    // Pair sum, two guard bits over a sample
    localparam int SUM_W = SAMPLE_W + 2;

    ////////////////////
    // Data types

    // Two simultaneous samples in one ADC word
    typedef struct packed {
        // Upper half of the word
        logic signed [SAMPLE_W-1:0] sample_hi;
        // Lower half of the word
        logic signed [SAMPLE_W-1:0] sample_lo;
    } adc_pair_t;

    // Sum of a sample pair, twice the channel mean
    typedef logic signed [SUM_W-1:0] adc_sum_t;

    // Both trigger thresholds, as written by software
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] level_a;
        logic signed [SAMPLE_W-1:0] level_b;
    } trig_levels_t;

    ////////////////////
    // Codes

    // Target of a write on the shared level port
    typedef enum logic [1:0] {
        LEVEL_NONE  = 2'd0,
        LEVEL_A     = 2'd1,
        LEVEL_B     = 2'd2,
        // Reserved, writes nothing
        LEVEL_SPARE = 2'd3
    } level_sel_e;

    // Trigger sequencer states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ARMED   = 2'd1,
        ST_HOLDOFF = 2'd2,
        ST_FIRE    = 2'd3
    } trig_state_e;

endpackage

// File: adc_pair_sum.sv
`timescale 1ns/1ns

module adc_pair_sum (
    input  logic                 adc_clk,
    input  logic                 trig_reset,
    // One ADC word, two samples
    input  trig_pkg::adc_pair_t  data,
    // Qualifies data on this edge
    input  logic                 enable,
    // Registered pair sum
    output trig_pkg::adc_sum_t   sum
);

    ////////////////////
    // Sign extension

    // Both samples widened to the sum width
    trig_pkg::adc_sum_t hi_ext;
    trig_pkg::adc_sum_t lo_ext;
    // Unregistered pair sum
    trig_pkg::adc_sum_t pair_sum;

    always_comb begin
        // Replicate the sign bit into the guard bits
        hi_ext = {{(trig_pkg::SUM_W - trig_pkg::SAMPLE_W){data.sample_hi[trig_pkg::SAMPLE_W-1]}},
                  data.sample_hi};
        lo_ext = {{(trig_pkg::SUM_W - trig_pkg::SAMPLE_W){data.sample_lo[trig_pkg::SAMPLE_W-1]}},
                  data.sample_lo};
        // Two guard bits, so no overflow and no clipping
        pair_sum = hi_ext + lo_ext;
    end

    ////////////////////
    // Sum register

    // Order of the samples does not matter for the sum
    always_ff @(posedge adc_clk) begin
        if (trig_reset) begin
            sum <= '0;
        end else if (enable) begin
            // New word only when the channel is enabled
            sum <= pair_sum;
        end
        // Otherwise hold the last enabled sum
    end

endmodule

// File: trig_level_regs.sv
`timescale 1ns/1ns

module trig_level_regs (
    input  logic                                 adc_clk,
    input  logic                                 trig_reset,
    // Which level the value goes to
    input  trig_pkg::level_sel_e                 level_sel,
    // Shared level write data
    input  logic signed [trig_pkg::SAMPLE_W-1:0] level_value,
    // Both thresholds, to the sequencer
    output trig_pkg::trig_levels_t               levels
);

    ////////////////////
    // Level registers

    // Written level is visible one cycle after the write edge
    always_ff @(posedge adc_clk) begin
        if (trig_reset) begin
            // Both thresholds back to zero
            levels <= '0;
        end else begin
            // Decode the select code
            case (level_sel)
                trig_pkg::LEVEL_A: begin
                    levels.level_a <= level_value;
                end
                trig_pkg::LEVEL_B: begin
                    levels.level_b <= level_value;
                end
                // LEVEL_NONE and LEVEL_SPARE write nothing
                default: begin
                    levels <= levels;
                end
            endcase
        end
    end

    ////////////////////
    // Checks

    // Software must always drive a defined select code
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        !$isunknown(level_sel))
    else $error("level_sel is unknown");

endmodule

// File: trigger_seq.sv
`timescale 1ns/1ns

module trigger_seq #(
    // Cycles spent in holdoff
    parameter int HOLDOFF_CYCLES = 255,
    // Width of the trigger1 pulse in cycles
    parameter int FIRE_CYCLES    = 1023,
    // Counter width, must hold both counts
    parameter int CNT_W          = 10
) (
    input  logic                   adc_clk,
    input  logic                   trig_reset,
    // Pair sums from the two channels
    input  trig_pkg::adc_sum_t     sum_a,
    input  trig_pkg::adc_sum_t     sum_b,
    // Thresholds from the level register
    input  trig_pkg::trig_levels_t levels,
    // High from armed until the end of fire
    output logic                   trigger0,
    // High only while firing
    output logic                   trigger1
);

    ////////////////////
    // Counter loads

    // Down-counter ends at zero, so load one less than the length
    localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(HOLDOFF_CYCLES - 1);
    localparam logic [CNT_W-1:0] FIRE_LOAD = CNT_W'(FIRE_CYCLES - 1);
    localparam logic [CNT_W-1:0] CNT_ONE   = CNT_W'(1);

    // State register and next state
    trig_pkg::trig_state_e state_q;
    trig_pkg::trig_state_e state_d;
    // Shared holdoff and fire counter
    logic [CNT_W-1:0]      cnt_q;
    logic [CNT_W-1:0]      cnt_d;
    logic                  cnt_zero;

    // Levels widened to the sum width
    trig_pkg::adc_sum_t    level_a_ext;
    trig_pkg::adc_sum_t    level_b_ext;
    // Rising-edge crossing on each channel
    logic                  cross_a;
    logic                  cross_b;

    ////////////////////
    // Level compare

    always_comb begin
        // Sign-extend the 16-bit levels
        level_a_ext = {{(trig_pkg::SUM_W - trig_pkg::SAMPLE_W)
                        {levels.level_a[trig_pkg::SAMPLE_W-1]}},
                       levels.level_a};
        level_b_ext = {{(trig_pkg::SUM_W - trig_pkg::SAMPLE_W)
                        {levels.level_b[trig_pkg::SAMPLE_W-1]}},
                       levels.level_b};
        // Strictly above, equal does not count
        cross_a = (sum_a > level_a_ext);
        cross_b = (sum_b > level_b_ext);
    end

    assign cnt_zero = (cnt_q == '0);

    ////////////////////
    // Next state

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            trig_pkg::ST_IDLE: begin
                // Wait for channel a
                if (cross_a) begin
                    state_d = trig_pkg::ST_ARMED;
                end
            end
            trig_pkg::ST_ARMED: begin
                // Wait for channel b, then start holdoff
                if (cross_b) begin
                    state_d = trig_pkg::ST_HOLDOFF;
                    cnt_d   = HOLD_LOAD;
                end
            end
            trig_pkg::ST_HOLDOFF: begin
                if (cnt_zero) begin
                    // Holdoff done, start the pulse
                    state_d = trig_pkg::ST_FIRE;
                    cnt_d   = FIRE_LOAD;
                end else begin
                    cnt_d = cnt_q - CNT_ONE;
                end
            end
            trig_pkg::ST_FIRE: begin
                if (cnt_zero) begin
                    // Pulse done, back to waiting
                    state_d = trig_pkg::ST_IDLE;
                end else begin
                    cnt_d = cnt_q - CNT_ONE;
                end
            end
            default: begin
                state_d = trig_pkg::ST_IDLE;
            end
        endcase
    end

    ////////////////////
    // State register

    always_ff @(posedge adc_clk) begin
        if (trig_reset) begin
            state_q <= trig_pkg::ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // Outputs decoded from the state register only
    assign trigger0 = (state_q != trig_pkg::ST_IDLE);
    assign trigger1 = (state_q == trig_pkg::ST_FIRE);

    ////////////////////
    // Checks

    // Fire pulse always sits inside an armed window opened earlier
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        trigger1 |-> trigger0 && $past(trigger0))
    else $error("trigger1 outside the armed window");

    // Holdoff run is exactly HOLDOFF_CYCLES long
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $fell(state_q == trig_pkg::ST_HOLDOFF) |->
            $past(state_q == trig_pkg::ST_HOLDOFF, HOLDOFF_CYCLES) &&
            !$past(state_q == trig_pkg::ST_HOLDOFF, HOLDOFF_CYCLES + 1))
    else $error("holdoff length wrong");

    // From idle only armed is reachable
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        (state_q == trig_pkg::ST_IDLE) |=>
            (state_q == trig_pkg::ST_IDLE || state_q == trig_pkg::ST_ARMED))
    else $error("sequencer skipped armed");

endmodule

// File: trigger_gen.sv
`timescale 1ns/1ns

module trigger_gen #(
    // Holdoff between the channel b crossing and fire
    parameter int HOLDOFF_CYCLES = 255,
    // Width of trigger1
    parameter int FIRE_CYCLES    = 1023,
    // Sequencer counter width
    parameter int CNT_W          = 10
) (
    input  logic                                 adc_clk,
    input  logic                                 trig_reset,
    // Channel a words and enable
    input  trig_pkg::adc_pair_t                  adc_data_a,
    input  logic                                 adc_enable_a,
    // Channel b words and enable
    input  trig_pkg::adc_pair_t                  adc_data_b,
    input  logic                                 adc_enable_b,
    // Shared level write port
    input  trig_pkg::level_sel_e                 level_sel,
    input  logic signed [trig_pkg::SAMPLE_W-1:0] level_value,
    // Armed window and fire pulse
    output logic                                 trigger0,
    output logic                                 trigger1
);

    ////////////////////
    // Internal wires

    // Registered pair sums
    trig_pkg::adc_sum_t     sum_a;
    trig_pkg::adc_sum_t     sum_b;
    // Current thresholds
    trig_pkg::trig_levels_t levels;

    ////////////////////
    // Channel sums

    // Channel a, the arming channel
    adc_pair_sum i_sum_a (
        .adc_clk    (adc_clk),
        .trig_reset (trig_reset),
        .data       (adc_data_a),
        .enable     (adc_enable_a),
        .sum        (sum_a)
    );

    // Channel b, the firing channel
    adc_pair_sum i_sum_b (
        .adc_clk    (adc_clk),
        .trig_reset (trig_reset),
        .data       (adc_data_b),
        .enable     (adc_enable_b),
        .sum        (sum_b)
    );

    ////////////////////
    // Levels and sequencer

    trig_level_regs i_levels (
        .adc_clk     (adc_clk),
        .trig_reset  (trig_reset),
        .level_sel   (level_sel),
        .level_value (level_value),
        .levels      (levels)
    );

    // Arm, holdoff and fire
    trigger_seq #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES),
        .FIRE_CYCLES    (FIRE_CYCLES),
        .CNT_W          (CNT_W)
    ) i_seq (
        .adc_clk    (adc_clk),
        .trig_reset (trig_reset),
        .sum_a      (sum_a),
        .sum_b      (sum_b),
        .levels     (levels),
        .trigger0   (trigger0),
        .trigger1   (trigger1)
    );

endmodule

// File: tb_trigger_gen.sv
`timescale 1ns/1ns

module tb_trigger_gen;

    ////////////////////
    // Parameters

    // Short holdoff and fire so the sequences stay brief
    localparam int HOLD_CYC = 8;
    localparam int FIRE_CYC = 6;
    localparam int CNT_W = 4;
    // Tests take about 140 cycles, so the limit leaves a wide margin
    localparam int MAX_CYCLES = 400;

    logic                                 adc_clk;
    logic                                 trig_reset;
    trig_pkg::adc_pair_t                  adc_data_a;
    logic                                 adc_enable_a;
    trig_pkg::adc_pair_t                  adc_data_b;
    logic                                 adc_enable_b;
    trig_pkg::level_sel_e                 level_sel;
    logic signed [trig_pkg::SAMPLE_W-1:0] level_value;
    logic                                 trigger0;
    logic                                 trigger1;

    // Expected thresholds, changed when a write is driven
    int          exp_lvl_a;
    int          exp_lvl_b;
    // Xorshift state
    logic [31:0] rng;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          cycles = 0;
    // Word on the input is above its level and enabled
    logic        word_cross_a;
    logic        word_cross_b;
    // Armed and still waiting for the first channel b crossing
    logic        b_open = 1'b1;

    trigger_gen #(
        .HOLDOFF_CYCLES (HOLD_CYC),
        .FIRE_CYCLES    (FIRE_CYC),
        .CNT_W          (CNT_W)
    ) i_dut (
        .adc_clk      (adc_clk),
        .trig_reset   (trig_reset),
        .adc_data_a   (adc_data_a),
        .adc_enable_a (adc_enable_a),
        .adc_data_b   (adc_data_b),
        .adc_enable_b (adc_enable_b),
        .level_sel    (level_sel),
        .level_value  (level_value),
        .trigger0     (trigger0),
        .trigger1     (trigger1)
    );

    initial begin
        adc_clk = 1'b0;
        forever #20 adc_clk = ~adc_clk;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % n);
    endfunction

    // Sign-extended sum of the two samples
    function automatic int pair_sum(input trig_pkg::adc_pair_t w);
        return int'(w.sample_hi) + int'(w.sample_lo);
    endfunction

    // Random split of a target sum over the two samples
    function automatic trig_pkg::adc_pair_t make_pair(input int target);
        trig_pkg::adc_pair_t w;
        int hi;
        hi = target / 2 + rand_below(64) - 32;
        w.sample_hi = 16'(hi);
        w.sample_lo = 16'(target - hi);
        return w;
    endfunction

    // Margin of 64 keeps clear of the threshold
    function automatic int below(input int lvl);
        return lvl - 64 - rand_below(2000);
    endfunction

    function automatic int above(input int lvl);
        return lvl + 64 + rand_below(500);
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    assign word_cross_a = adc_enable_a && (pair_sum(adc_data_a) > exp_lvl_a);
    assign word_cross_b = adc_enable_b && (pair_sum(adc_data_b) > exp_lvl_b);

    always @(posedge adc_clk) begin
        if (trig_reset || !trigger0) begin
            b_open <= 1'b1;
        end else if (word_cross_b) begin
            b_open <= 1'b0;
        end
    end

    ////////////////////
    // Checks

    // Both triggers low once reset ends
    assert property (@(posedge adc_clk) $fell(trig_reset) |-> !trigger0 && !trigger1)
    else log_error("triggers not low after reset");

    // Channel a crossing in idle arms two edges later
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $past(word_cross_a && !trigger0, 2) |-> trigger0 && !$past(trigger0))
    else log_error("trigger0 did not rise 2 cycles after the channel a crossing");

    // No arming without a crossing
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $rose(trigger0) |-> $past(word_cross_a && !trigger0, 2))
    else log_error("trigger0 rose without a channel a crossing");

    // Fire after the holdoff
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $past(word_cross_b && trigger0 && b_open, 2 + HOLD_CYC) |-> $rose(trigger1))
    else log_error("trigger1 did not rise 2 plus holdoff cycles after channel b");

    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $rose(trigger1) |-> $past(word_cross_b && trigger0 && b_open, 2 + HOLD_CYC))
    else log_error("trigger1 rose without an armed channel b crossing");

    // Pulse width
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $fell(trigger1) |-> $past(trigger1, FIRE_CYC) && !$past(trigger1, FIRE_CYC + 1))
    else log_error("trigger1 width differs from the fire length");

    // Both fall on the same edge
    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $fell(trigger0) |-> $fell(trigger1))
    else log_error("trigger0 fell without trigger1");

    assert property (@(posedge adc_clk) disable iff (trig_reset)
        $fell(trigger1) |-> $fell(trigger0))
    else log_error("trigger1 fell while trigger0 stayed high");

    ////////////////////
    // Stimulus

    // One cycle of words on both channels
    task automatic drive_words(input int s_a, input logic en_a, input int s_b, input logic en_b);
        @(posedge adc_clk);
        #2;
        adc_data_a = make_pair(s_a);
        adc_enable_a = en_a;
        adc_data_b = make_pair(s_b);
        adc_enable_b = en_b;
        level_sel = trig_pkg::LEVEL_NONE;
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) drive_words(below(exp_lvl_a), 1'b1, below(exp_lvl_b), 1'b1);
    endtask

    // Words stay below the new levels in the write cycle
    task automatic write_level(input trig_pkg::level_sel_e sel, input int value);
        @(posedge adc_clk);
        #2;
        if (sel == trig_pkg::LEVEL_A) begin
            exp_lvl_a = value;
        end else if (sel == trig_pkg::LEVEL_B) begin
            exp_lvl_b = value;
        end
        level_sel = sel;
        level_value = 16'(value);
        adc_data_a = make_pair(below(exp_lvl_a));
        adc_enable_a = 1'b1;
        adc_data_b = make_pair(below(exp_lvl_b));
        adc_enable_b = 1'b1;
    endtask

    // Quiet words until a trigger reaches a value
    task automatic wait_for(input logic on_t1, input logic value, input string what);
        int guard;
        guard = 0;
        while (((on_t1 ? trigger1 : trigger0) != value) && guard < 40) begin
            quiet_cycles(1);
            guard++;
        end
        if ((on_t1 ? trigger1 : trigger0) != value) begin
            log_failure({"gave up waiting for ", what});
        end
    endtask

    task automatic report_test(input string name);
        trig_pkg::trig_state_e st;
        st = i_dut.i_seq.state_q;
        tests_run++;
        $display("test %0d %s: %s, state %s", tests_run, name,
                 (errors == errors_at_start) ? "ok" : "failed", st.name());
        errors_at_start = errors;
    endtask

    // Arm on channel a, fire on channel b, wait for idle
    task automatic run_sequence(input int a_sum);
        drive_words(a_sum, 1'b1, below(exp_lvl_b), 1'b1);
        wait_for(1'b0, 1'b1, "trigger0 to rise");
        quiet_cycles(2);
        drive_words(below(exp_lvl_a), 1'b1, above(exp_lvl_b), 1'b1);
        wait_for(1'b0, 1'b0, "the sequence to end");
    endtask

    initial begin
        trig_reset = 1'b1;
        adc_data_a = '0;
        adc_enable_a = 1'b0;
        adc_data_b = '0;
        adc_enable_b = 1'b0;
        level_sel = trig_pkg::LEVEL_NONE;
        level_value = '0;
        rng = 32'd40;
        exp_lvl_a = 0;
        exp_lvl_b = 0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        repeat (4) @(posedge adc_clk);
        #2;
        trig_reset = 1'b0;

        // Levels are zero, negative sums only
        quiet_cycles(12);
        report_test("idle after reset");

        write_level(trig_pkg::LEVEL_A, 3000);
        write_level(trig_pkg::LEVEL_B, -1500);
        // Spare must not lower level a
        write_level(trig_pkg::LEVEL_SPARE, 1000);
        quiet_cycles(2);
        drive_words(2000, 1'b1, below(exp_lvl_b), 1'b1);
        quiet_cycles(6);
        report_test("level write");

        run_sequence(above(exp_lvl_a));
        quiet_cycles(3);
        report_test("full sequence");

        // Channel b alone in idle
        drive_words(below(exp_lvl_a), 1'b1, above(exp_lvl_b), 1'b1);
        quiet_cycles(14);
        // Channel a again in holdoff and in fire
        drive_words(above(exp_lvl_a), 1'b1, below(exp_lvl_b), 1'b1);
        wait_for(1'b0, 1'b1, "trigger0 to rise");
        quiet_cycles(1);
        drive_words(below(exp_lvl_a), 1'b1, above(exp_lvl_b), 1'b1);
        quiet_cycles(3);
        drive_words(above(exp_lvl_a), 1'b1, below(exp_lvl_b), 1'b1);
        wait_for(1'b1, 1'b1, "trigger1 to rise");
        drive_words(above(exp_lvl_a), 1'b1, below(exp_lvl_b), 1'b1);
        wait_for(1'b0, 1'b0, "the sequence to end");
        quiet_cycles(4);
        report_test("ignored crossings");

        repeat (3) drive_words(above(exp_lvl_a), 1'b0, below(exp_lvl_b), 1'b1);
        quiet_cycles(4);
        report_test("enable gating");

        write_level(trig_pkg::LEVEL_A, 700);
        quiet_cycles(2);
        // Equal is not above
        drive_words(700, 1'b1, below(exp_lvl_b), 1'b1);
        quiet_cycles(4);
        run_sequence(701);
        quiet_cycles(3);
        report_test("strict compare");

        $display("tests %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    ////////////////////
    // Timeout

    always @(posedge adc_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// File: trigger_gen.f
trig_pkg.sv
adc_pair_sum.sv
trig_level_regs.sv
trigger_seq.sv
trigger_gen.sv
tb_trigger_gen.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_trigger_gen
FILELIST = trigger_gen.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Finished with errors
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
